// ==== logic/dispatch_params.svh ====
`ifndef DISPATCH_PARAMS_SVH
`define DISPATCH_PARAMS_SVH

// lanes per warp and the width of a lane number
`define NUM_LANES 4
`define LANE_BITS 2

// register data width
`define XLEN 32

// per-unit stall counters
`define PERF_CTR_BITS 16

// instructions allowed between dispatch and commit
// the count saturates at INFLIGHT_MAX
`define INFLIGHT_MAX 7
`define INFLIGHT_BITS 3

`endif

// ==== logic/dispatch_pkg.sv ====
`default_nettype none

`include "dispatch_params.svh"

package dispatch_pkg;

    // target functional unit, code 2'd3 is not assigned
    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_SFU = 2'd2
    } ex_type_e;

    typedef logic [`NUM_LANES-1:0]     lane_mask_t;
    typedef logic [`LANE_BITS-1:0]     lane_idx_t;
    typedef logic [`XLEN-1:0]          word_t;
    typedef logic [`INFLIGHT_BITS-1:0] inflight_t;
    typedef logic [`PERF_CTR_BITS-1:0] perf_ctr_t;

    // instruction as it leaves operand collection
    typedef struct packed {
        ex_type_e                  ex_type;
        logic                      is_branch;
        logic [3:0]                op;
        lane_mask_t                tmask;
        word_t                     pc;
        logic [4:0]                rd;
        word_t [`NUM_LANES-1:0]    rs1_data;
        word_t [`NUM_LANES-1:0]    rs2_data;
    } operands_t;

    // what a functional unit queue carries
    typedef struct packed {
        logic                      is_branch;
        logic [3:0]                op;
        lane_mask_t                tmask;
        word_t                     pc;
        logic [4:0]                rd;
        word_t [`NUM_LANES-1:0]    rs1_data;
        word_t [`NUM_LANES-1:0]    rs2_data;
        lane_idx_t                 last_lane;
    } dispatch_t;

    typedef enum logic [1:0] {
        S_OPEN,
        S_DRAIN,
        S_BRANCH
    } staller_state_e;

endpackage

`default_nettype wire

// ==== logic/inflight_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_params.svh"

module inflight_counter (
    input wire                  clk,
    input wire                  reset,
    input wire                  flush,
    input wire                  incr,
    input wire                  decr,
    output dispatch_pkg::inflight_t count,
    output logic                empty
);
    import dispatch_pkg::*;

    inflight_t count_n;

    // incr and decr together leave the count unchanged
    always_comb begin
        count_n = count;
        if (incr && !decr) begin
            if (count != inflight_t'(`INFLIGHT_MAX)) begin
                count_n = count + inflight_t'(1);
            end
        end else if (decr && !incr) begin
            if (count != '0) begin
                count_n = count - inflight_t'(1);
            end
        end
    end

    // empty is kept as a flop so pipe_empty has no adder in its path
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            count <= '0;
            empty <= 1'b1;
        end else begin
            count <= count_n;
            empty <= (count_n == '0);
        end
    end

endmodule

`default_nettype wire

// ==== logic/branch_staller.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_staller (
    input wire   clk,
    input wire   reset,
    input wire   flush,
    input wire   in_valid,
    input wire   is_branch,
    input wire   accept,
    input wire   pipe_empty,
    output logic issue_allow
);
    import dispatch_pkg::*;

    staller_state_e state;
    staller_state_e state_n;

    always_comb begin
        state_n     = state;
        issue_allow = 1'b0;
        case (state)
            S_OPEN: begin
                // a branch only goes out into an empty execute stage
                issue_allow = !is_branch || pipe_empty;
                if (accept && is_branch) begin
                    state_n = S_BRANCH;
                end else if (in_valid && is_branch && !pipe_empty) begin
                    state_n = S_DRAIN;
                end
            end
            S_DRAIN: begin
                // hold younger work back until the branch can go
                if (pipe_empty) begin
                    state_n = S_OPEN;
                end
            end
            S_BRANCH: begin
                // wait for the branch itself to commit
                if (pipe_empty) begin
                    state_n = S_OPEN;
                end
            end
            default: begin
                state_n = S_OPEN;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            state <= S_OPEN;
        end else begin
            state <= state_n;
        end
    end

endmodule

`default_nettype wire

// ==== logic/last_lane_finder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_params.svh"

module last_lane_finder (
    input wire dispatch_pkg::lane_mask_t tmask,
    output dispatch_pkg::lane_idx_t      last_lane
);
    import dispatch_pkg::*;

    // scan upward so the highest set lane wins
    // an empty mask falls through to lane 0
    always_comb begin
        last_lane = '0;
        for (int i = 0; i < `NUM_LANES; i++) begin
            if (tmask[i]) begin
                last_lane = lane_idx_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/fu_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module fu_buffer #(
    parameter int DEPTH_LOG = 1
) (
    input wire                           clk,
    input wire                           reset,
    input wire                           flush,
    input wire                           in_valid,
    input wire dispatch_pkg::dispatch_t  in_data,
    output logic                         in_ready,
    output logic                         out_valid,
    output dispatch_pkg::dispatch_t      out_data,
    input wire                           out_ready,
    output logic                         empty
);
    import dispatch_pkg::*;

    localparam int DEPTH = 1 << DEPTH_LOG;

    dispatch_t            mem [DEPTH];
    logic [DEPTH_LOG-1:0] wr_ptr;
    logic [DEPTH_LOG-1:0] rd_ptr;
    logic [DEPTH_LOG:0]   count;
    logic                 push;
    logic                 pop;
    dispatch_t            head_next;

    assign in_ready = (count < (DEPTH_LOG + 1)'(DEPTH));
    assign push     = in_valid && in_ready;
    assign pop      = out_valid && out_ready;
    assign empty    = !out_valid;

    // next head is the second stored entry, or the incoming one when the queue runs dry
    assign head_next = (count > (DEPTH_LOG + 1)'(1)) ? mem[rd_ptr + DEPTH_LOG'(1)] : in_data;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + DEPTH_LOG'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + DEPTH_LOG'(1);
            end
            count     <= count + (DEPTH_LOG + 1)'(push) - (DEPTH_LOG + 1)'(pop);
            out_valid <= (count + (DEPTH_LOG + 1)'(push) - (DEPTH_LOG + 1)'(pop)) != '0;
        end
    end

    // storage keeps the head too, out_data is its registered copy
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
        if (pop || empty) begin
            out_data <= head_next;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dispatch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module dispatch_unit (
    input wire                           clk,
    input wire                           reset,
    input wire                           flush,
    input wire                           commit,
    input wire                           operands_valid,
    input wire dispatch_pkg::operands_t  operands,
    output logic                         operands_ready,
    output wire                          alu_dispatch_valid,
    output dispatch_pkg::dispatch_t      alu_dispatch_data,
    input wire                           alu_dispatch_ready,
    output wire                          lsu_dispatch_valid,
    output dispatch_pkg::dispatch_t      lsu_dispatch_data,
    input wire                           lsu_dispatch_ready,
    output wire                          sfu_dispatch_valid,
    output dispatch_pkg::dispatch_t      sfu_dispatch_data,
    input wire                           sfu_dispatch_ready,
    output dispatch_pkg::perf_ctr_t      stall_alu,
    output dispatch_pkg::perf_ctr_t      stall_lsu,
    output dispatch_pkg::perf_ctr_t      stall_sfu
);
    import dispatch_pkg::*;

    lane_idx_t  last_lane;
    dispatch_t  dispatch_in;
    logic       inflight_empty;
    logic       issue_allow;
    logic       accept;
    logic       stalled;
    logic       pipe_empty;
    logic [2:0] sel;
    logic [2:0] buf_ready;
    logic [2:0] buf_empty;
    logic [2:0] handover;

    // one-hot queue select, the unused code selects nothing
    assign sel[EX_ALU] = (operands.ex_type == EX_ALU);
    assign sel[EX_LSU] = (operands.ex_type == EX_LSU);
    assign sel[EX_SFU] = (operands.ex_type == EX_SFU);

    assign operands_ready = issue_allow && |(sel & buf_ready) && !flush;
    assign accept         = operands_valid && operands_ready;
    assign stalled        = operands_valid && !operands_ready;
    assign pipe_empty     = inflight_empty && &buf_empty;

    assign handover[EX_ALU] = alu_dispatch_valid && alu_dispatch_ready;
    assign handover[EX_LSU] = lsu_dispatch_valid && lsu_dispatch_ready;
    assign handover[EX_SFU] = sfu_dispatch_valid && sfu_dispatch_ready;

    always_comb begin
        dispatch_in.is_branch = operands.is_branch;
        dispatch_in.op        = operands.op;
        dispatch_in.tmask     = operands.tmask;
        dispatch_in.pc        = operands.pc;
        dispatch_in.rd        = operands.rd;
        dispatch_in.rs1_data  = operands.rs1_data;
        dispatch_in.rs2_data  = operands.rs2_data;
        dispatch_in.last_lane = last_lane;
    end

    last_lane_finder last_lane_i (.tmask(operands.tmask), .last_lane(last_lane));

    branch_staller staller_i (
        .clk(clk), .reset(reset), .flush(flush),
        .in_valid(operands_valid), .is_branch(operands.is_branch),
        .accept(accept), .pipe_empty(pipe_empty), .issue_allow(issue_allow)
    );

    // single issue slot, the execute stage takes at most one instruction per cycle
    inflight_counter inflight_i (
        .clk(clk), .reset(reset), .flush(flush),
        .incr(|handover), .decr(commit),
        .count(), .empty(inflight_empty)
    );

    fu_buffer #(.DEPTH_LOG(1)) alu_buffer (
        .clk(clk), .reset(reset), .flush(flush),
        .in_valid(accept && sel[EX_ALU]), .in_data(dispatch_in), .in_ready(buf_ready[EX_ALU]),
        .out_valid(alu_dispatch_valid), .out_data(alu_dispatch_data),
        .out_ready(alu_dispatch_ready), .empty(buf_empty[EX_ALU])
    );

    fu_buffer #(.DEPTH_LOG(1)) lsu_buffer (
        .clk(clk), .reset(reset), .flush(flush),
        .in_valid(accept && sel[EX_LSU]), .in_data(dispatch_in), .in_ready(buf_ready[EX_LSU]),
        .out_valid(lsu_dispatch_valid), .out_data(lsu_dispatch_data),
        .out_ready(lsu_dispatch_ready), .empty(buf_empty[EX_LSU])
    );

    fu_buffer #(.DEPTH_LOG(1)) sfu_buffer (
        .clk(clk), .reset(reset), .flush(flush),
        .in_valid(accept && sel[EX_SFU]), .in_data(dispatch_in), .in_ready(buf_ready[EX_SFU]),
        .out_valid(sfu_dispatch_valid), .out_data(sfu_dispatch_data),
        .out_ready(sfu_dispatch_ready), .empty(buf_empty[EX_SFU])
    );

    // cycles an instruction waits at the input, by target unit
    always_ff @(posedge clk) begin
        if (reset) begin
            stall_alu <= '0;
            stall_lsu <= '0;
            stall_sfu <= '0;
        end else begin
            if (stalled && sel[EX_ALU]) begin
                stall_alu <= stall_alu + perf_ctr_t'(1);
            end
            if (stalled && sel[EX_LSU]) begin
                stall_lsu <= stall_lsu + perf_ctr_t'(1);
            end
            if (stalled && sel[EX_SFU]) begin
                stall_sfu <= stall_sfu + perf_ctr_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/dispatch_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module dispatch_assertions (
    input wire                             clk,
    input wire                             reset,
    input wire                             flush,
    input wire                             operands_valid,
    input wire                             operands_ready,
    input wire [2:0]                       out_valid,
    input wire [2:0]                       out_ready,
    input wire dispatch_pkg::dispatch_t    alu_data,
    input wire dispatch_pkg::dispatch_t    lsu_data,
    input wire dispatch_pkg::dispatch_t    sfu_data,
    input wire dispatch_pkg::staller_state_e staller_state
);
    import dispatch_pkg::*;

    // queues come out of reset empty
    a_reset_idle: assert property (@(posedge clk) reset |=> out_valid == 3'b000)
        else $error("dispatch valid high after reset");

    a_alu_hold: assert property (@(posedge clk) disable iff (reset || flush)
        out_valid[0] && !out_ready[0] |=> out_valid[0] && $stable(alu_data))
        else $error("alu output changed under back-pressure");

    a_lsu_hold: assert property (@(posedge clk) disable iff (reset || flush)
        out_valid[1] && !out_ready[1] |=> out_valid[1] && $stable(lsu_data))
        else $error("lsu output changed under back-pressure");

    a_sfu_hold: assert property (@(posedge clk) disable iff (reset || flush)
        out_valid[2] && !out_ready[2] |=> out_valid[2] && $stable(sfu_data))
        else $error("sfu output changed under back-pressure");

    a_accept_open: assert property (@(posedge clk) disable iff (reset)
        operands_valid && operands_ready |-> staller_state == S_OPEN)
        else $error("operands accepted while staller closed");

    a_flush_block: assert property (@(posedge clk) flush |-> !operands_ready)
        else $error("operands ready during flush");

endmodule

`default_nettype wire

// ==== bench/dispatch_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dispatch_params.svh"

module dispatch_tb;
    import dispatch_pkg::*;

    typedef struct packed {
        ex_type_e   ex;
        logic       br;
        lane_mask_t tmask;
        logic [2:0] rdy_en;
        logic [2:0] delay;
        logic       fl;
    } row_t;

    localparam int NUM_ROWS = 15;
    localparam int LIMIT    = NUM_ROWS * 40;

    logic      clk = 1'b0;
    logic      reset, flush, commit, operands_valid, operands_ready;
    operands_t operands;
    logic      alu_dispatch_valid, lsu_dispatch_valid, sfu_dispatch_valid;
    dispatch_t alu_dispatch_data, lsu_dispatch_data, sfu_dispatch_data;
    logic      alu_dispatch_ready, lsu_dispatch_ready, sfu_dispatch_ready;
    perf_ctr_t stall_alu, stall_lsu, stall_sfu;

    logic [2:0] sink_valid;
    logic [2:0] sink_ready;
    dispatch_t  sink_data [3];
    row_t       rows [NUM_ROWS];
    row_t       cur;
    logic [5:0] pat [3];
    dispatch_t  exp_q [3][$];
    int         delay_q [3][$];
    int         commit_due [$];
    int         stall_model [3];
    int         inflight_model, cyc, idx;
    logic       branch_pending, after_flush, busy;

    dispatch_unit dut_i (.*);

    bind dispatch_unit dispatch_assertions assert_i (
        .clk(clk), .reset(reset), .flush(flush),
        .operands_valid(operands_valid), .operands_ready(operands_ready),
        .out_valid({sfu_dispatch_valid, lsu_dispatch_valid, alu_dispatch_valid}),
        .out_ready({sfu_dispatch_ready, lsu_dispatch_ready, alu_dispatch_ready}),
        .alu_data(alu_dispatch_data), .lsu_data(lsu_dispatch_data),
        .sfu_data(sfu_dispatch_data), .staller_state(staller_i.state)
    );

    assign sink_valid   = {sfu_dispatch_valid, lsu_dispatch_valid, alu_dispatch_valid};
    assign sink_ready   = {sfu_dispatch_ready, lsu_dispatch_ready, alu_dispatch_ready};
    assign sink_data[0] = alu_dispatch_data;
    assign sink_data[1] = lsu_dispatch_data;
    assign sink_data[2] = sfu_dispatch_data;

    always #5 clk = !clk;

    task automatic check(input logic [511:0] act, input logic [511:0] exp, input string msg);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s (got %0h, expected %0h)", $time, msg, act, exp);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // search downward, the first set lane is the last active one
    function automatic lane_idx_t highest_lane(input lane_mask_t mask);
        lane_idx_t res;
        logic      found;
        res   = '0;
        found = 1'b0;
        for (int i = `NUM_LANES - 1; i >= 0; i--) begin
            if (mask[i] && !found) begin
                res   = lane_idx_t'(i);
                found = 1'b1;
            end
        end
        return res;
    endfunction

    function automatic dispatch_t expected_of(input operands_t o);
        dispatch_t d;
        d.is_branch = o.is_branch;
        d.op        = o.op;
        d.tmask     = o.tmask;
        d.pc        = o.pc;
        d.rd        = o.rd;
        d.rs1_data  = o.rs1_data;
        d.rs2_data  = o.rs2_data;
        d.last_lane = highest_lane(o.tmask);
        return d;
    endfunction

    function automatic logic model_busy();
        return inflight_model != 0 || exp_q[0].size() != 0 || exp_q[1].size() != 0
            || exp_q[2].size() != 0;
    endfunction

    always @(posedge clk) begin
        if (cyc > LIMIT) begin
            $display("Test FAILED");
            $fatal(1, "timeout: the dispatch stage stopped making progress");
        end
    end

    // sinks take turns in disjoint slots, so at most one handover per cycle
    always @(negedge clk) begin
        idx                = cyc % 6;
        alu_dispatch_ready = cur.rdy_en[0] && pat[0][idx];
        lsu_dispatch_ready = cur.rdy_en[1] && pat[1][idx];
        sfu_dispatch_ready = cur.rdy_en[2] && pat[2][idx];
        commit             = 1'b0;
        if (!reset && commit_due.size() != 0 && commit_due[0] <= cyc) begin
            commit = 1'b1;
            void'(commit_due.pop_front());
        end
    end

    // scoreboard on the sampled edge
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (!reset) begin
            busy = model_busy();
            if (after_flush) begin
                check(512'(sink_valid), 512'(0), "dispatch valid after flush");
            end
            after_flush = 1'b0;
            if (operands_valid && operands.ex_type != 2'd3) begin
                if (exp_q[operands.ex_type].size() == 2) begin
                    check(512'(operands_ready), 512'(0), "input accepted into a full queue");
                end
                if (!operands_ready) begin
                    stall_model[operands.ex_type]++;
                end
            end
            for (int u = 0; u < 3; u++) begin
                if (sink_valid[u]) begin
                    check(512'(exp_q[u].size() != 0), 512'(1), "output valid, nothing expected");
                    check(512'(sink_data[u]), 512'(exp_q[u][0]), "wrong dispatch data");
                    if (sink_ready[u]) begin
                        void'(exp_q[u].pop_front());
                        commit_due.push_back(cyc + delay_q[u].pop_front());
                        inflight_model++;
                    end
                end
            end
            if (commit && inflight_model > 0) begin
                inflight_model--;
            end
            if (operands_valid && operands_ready) begin
                check(512'(branch_pending), 512'(0), "instruction accepted before branch commit");
            end
            if (branch_pending && !busy) begin
                branch_pending = 1'b0;
            end
            if (operands_valid && operands_ready) begin
                check(512'(operands.ex_type != 2'd3), 512'(1), "unused unit type accepted");
                exp_q[operands.ex_type].push_back(expected_of(operands));
                delay_q[operands.ex_type].push_back(int'(cur.delay));
                if (operands.is_branch) begin
                    check(512'(busy), 512'(0), "branch accepted with work in flight");
                    branch_pending = 1'b1;
                end
            end
            if (flush) begin
                for (int u = 0; u < 3; u++) begin
                    exp_q[u].delete();
                    delay_q[u].delete();
                end
                commit_due.delete();
                inflight_model = 0;
                branch_pending = 1'b0;
                after_flush    = 1'b1;
            end
        end
    end

    task automatic present_row(input row_t r);
        operands.ex_type   = r.ex;
        operands.is_branch = r.br;
        operands.tmask     = r.tmask;
        operands.op        = 4'($urandom());
        operands.pc        = word_t'($urandom());
        operands.rd        = 5'($urandom());
        for (int l = 0; l < `NUM_LANES; l++) begin
            operands.rs1_data[l] = word_t'($urandom());
            operands.rs2_data[l] = word_t'($urandom());
        end
        operands_valid = 1'b1;
        if (r.ex == 2'd3) begin
            // no queue takes this code, so the port has to keep refusing it
            repeat (4) @(posedge clk);
        end else begin
            do begin
                @(posedge clk);
            end while (!(operands_valid && operands_ready));
        end
    endtask

    initial begin
        void'($urandom(40));
        reset = 1'b1;
        flush = 1'b0;
        commit = 1'b0;
        operands_valid = 1'b0;
        operands = '0;
        alu_dispatch_ready = 1'b0;
        lsu_dispatch_ready = 1'b0;
        sfu_dispatch_ready = 1'b0;
        inflight_model = 0;
        branch_pending = 1'b0;
        after_flush = 1'b0;
        stall_model = '{0, 0, 0};
        cur <= '0;
        pat <= '{6'b000001, 6'b000010, 6'b000100};
        // ex, branch, tmask, ready enables {sfu,lsu,alu}, commit delay, flush
        rows[0]  = '{EX_ALU, 1'b0, 4'b1111, 3'b111, 3'd2, 1'b0};
        rows[1]  = '{EX_LSU, 1'b0, 4'b0011, 3'b111, 3'd3, 1'b0};
        rows[2]  = '{EX_SFU, 1'b0, 4'b0100, 3'b111, 3'd1, 1'b0};
        rows[3]  = '{EX_ALU, 1'b1, 4'b1000, 3'b111, 3'd4, 1'b0};
        rows[4]  = '{EX_ALU, 1'b0, 4'b0110, 3'b111, 3'd2, 1'b0};
        rows[5]  = '{EX_LSU, 1'b0, 4'b0000, 3'b101, 3'd1, 1'b0};
        rows[6]  = '{EX_LSU, 1'b0, 4'b0001, 3'b101, 3'd2, 1'b0};
        rows[7]  = '{EX_LSU, 1'b0, 4'b1010, 3'b111, 3'd3, 1'b0};
        rows[8]  = '{EX_LSU, 1'b1, 4'b0101, 3'b111, 3'd2, 1'b0};
        rows[9]  = '{EX_SFU, 1'b0, 4'b1100, 3'b011, 3'd1, 1'b0};
        rows[10] = '{EX_SFU, 1'b0, 4'b0010, 3'b011, 3'd1, 1'b0};
        rows[11] = '{EX_ALU, 1'b0, 4'b1001, 3'b111, 3'd2, 1'b1};
        rows[12] = '{EX_LSU, 1'b1, 4'b0010, 3'b111, 3'd1, 1'b0};
        rows[13] = '{EX_SFU, 1'b0, 4'b1111, 3'b111, 3'd5, 1'b0};
        rows[14] = '{ex_type_e'(2'd3), 1'b0, 4'b0110, 3'b111, 3'd1, 1'b0};
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(negedge clk);
            operands_valid = 1'b0;
            // sink settings of a row take effect from the next falling edge
            cur    <= rows[i];
            pat[0] <= 6'b000001 | (6'($urandom()) & 6'b001000);
            pat[1] <= 6'b000010 | (6'($urandom()) & 6'b010000);
            pat[2] <= 6'b000100 | (6'($urandom()) & 6'b100000);
            if (rows[i].fl) begin
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
            end
            present_row(rows[i]);
        end
        @(negedge clk);
        operands_valid = 1'b0;
        cur.rdy_en <= 3'b111;
        while (model_busy() || commit_due.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        check(512'(stall_alu), 512'(stall_model[0]), "alu stall counter");
        check(512'(stall_lsu), 512'(stall_model[1]), "lsu stall counter");
        check(512'(stall_sfu), 512'(stall_model[2]), "sfu stall counter");
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+logic
logic/dispatch_pkg.sv
logic/inflight_counter.sv
logic/branch_staller.sv
logic/last_lane_finder.sv
logic/fu_buffer.sv
logic/dispatch_unit.sv
bench/dispatch_assertions.sv
bench/dispatch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dispatch_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
